/* verification/spiVectors.txt */
# op addr data expect, hex fields after the op letter
# W write, R read, M C T master, S slave, A ack, I irq line, F mode fault
W 2C 50 00
R 2C 00 50
R 2D 00 00
M 2E A5 A5
W 2C 75 00
M 2E 3C 3C
W 2D 01 00
R 2D 00 01
W 2C 5A 00
M 2E C3 C3
W 2C 7F 00
M 2E 96 96
W 2D 00 00
W 2C 50 00
C 2E 5A 5A
R 2D 00 00
W 2C D0 00
T 2E 81 00
I 00 00 01
A 11 00 00
I 00 00 00
T 2E 42 00
R 2D 00 80
R 2E 00 42
I 00 00 00
F 00 00 00
R 2C 00 C0
R 2D 00 80
R 2E 00 42
W 2C 40 00
W 2E 69 00
S 00 A7 69
R 2D 00 80
R 2E 00 A7
W 2C 6C 00
W 2E 1E 00
S 00 D2 1E
R 2D 00 80
R 2E 00 D2

/* project.f */
src/spiPkg.sv
src/spiControlRegs.sv
src/spiStatusFlags.sv
src/spiMaster.sv
src/spiSlave.sv
src/spiShifter.sv
src/spiTop.sv
verification/spiTb.sv

/* run.sh */
#!/bin/sh
# Build the SPI testbench with Verilator, run it and look for the pass line
verilator --binary --timing --top-module spiTb -f project.f || exit 1
simOut=$(./obj_dir/VspiTb)
echo "$simOut"
echo "$simOut" | grep -qx 'Done: no errors' && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

/* verification/spiTb.sv */
module spiTb;

	localparam int clkPeriod     = 4;
	localparam int resetCycles   = 4;
	localparam int halfBitCycles = 16;	// Slave bit-bang half-period
	localparam int vectorBudget  = 4200;	// Time units allowed per vector
	localparam int maxVectors    = 64;

	logic           cp2;
	logic           irst;
	spiPkg::ioAddrT ioAddr;
	logic           ioRe;
	logic           ioWe;
	spiPkg::byteT   dbusIn;
	spiPkg::byteT   dbusOut;
	logic           outEn;
	logic           miso;
	logic           mosi;
	logic           sck;
	logic           ss;
	logic           sckO;
	logic           mosiO;
	logic           misoO;
	logic           spiIrq;
	spiPkg::ioAddrT irqAckAddr;
	logic           irqAck;
	logic           loopBack;	// Master ops feed MOSI back to MISO

	spiPkg::byteT opTab   [maxVectors];
	spiPkg::byteT addrTab [maxVectors];
	spiPkg::byteT dataTab [maxVectors];
	spiPkg::byteT expTab  [maxVectors];
	int           vecCount;
	logic         vecLoaded;

	// Expected configuration tracked from bus writes
	spiPkg::byteT ctrlShadow;
	logic         spi2xShadow;

	int errorCount;
	int checkCount;

	always #(clkPeriod / 2) cp2 = ~cp2;

	assign miso = loopBack ? mosiO : 1'b1;

	spiTop i_spiTop (
		.cp2         (cp2),
		.irst        (irst),
		.ioAddr_i    (ioAddr),
		.ioRe_i      (ioRe),
		.ioWe_i      (ioWe),
		.dbus_i      (dbusIn),
		.dbus_o      (dbusOut),
		.outEn_o     (outEn),
		.miso_i      (miso),
		.mosi_i      (mosi),
		.sck_i       (sck),
		.ss_i        (ss),
		.sckO_o      (sckO),
		.mosiO_o     (mosiO),
		.misoO_o     (misoO),
		.spiIrq_o    (spiIrq),
		.irqAckAddr_i(irqAckAddr),
		.irqAck_i    (irqAck)
	);

	//********************
	// Result checks
	//********************
	task automatic checkByte(input string name, input spiPkg::byteT got,
		input spiPkg::byteT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compareLength(input string name, input int got, input int exp);
		checkCount++;
		if (got != exp) begin
			errorCount++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Clock divide ratio from SPR and SPI2X
	function automatic int divideRatio(input logic dbl, input logic [1:0] spr);
		int ratio;
		case (spr)
			2'b00:   ratio = 4;
			2'b01:   ratio = 16;
			2'b10:   ratio = 64;
			default: ratio = 128;
		endcase
		if (dbl) begin
			ratio = ratio / 2;
		end
		return ratio;
	endfunction

	// Tasks start and end 1 time unit after a rising edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge cp2);
		#1;
	endtask

	task automatic busWrite(input spiPkg::ioAddrT addr, input spiPkg::byteT data);
		ioAddr = addr;
		dbusIn = data;
		ioWe   = 1'b1;
		@(posedge cp2);
		#1;
		ioWe   = 1'b0;
		ioAddr = '0;
		if (addr == spiPkg::defaultSpcrAddr) begin
			ctrlShadow = data;
		end else if (addr == spiPkg::defaultSpsrAddr) begin
			spi2xShadow = data[spiPkg::spi2xBit];
		end
	endtask

	task automatic busRead(input spiPkg::ioAddrT addr, output spiPkg::byteT data,
		output logic en);
		ioAddr = addr;
		ioRe   = 1'b1;
		@(negedge cp2);
		data = dbusOut;
		en   = outEn;
		@(posedge cp2);
		#1;
		ioRe   = 1'b0;
		ioAddr = '0;
	endtask

	//********************
	// Serial transfers
	//********************
	task automatic masterTransfer(input spiPkg::ioAddrT addr, input spiPkg::byteT data,
		input spiPkg::byteT exp, input logic readBack, input logic collide);
		int           cycles;
		int           ratio;
		int           sckEdges;
		logic         sckLast;
		logic         flagSeen;
		logic         en;
		spiPkg::byteT status;
		spiPkg::byteT rx;
		ratio    = divideRatio(spi2xShadow, ctrlShadow[1:0]);
		loopBack = 1'b1;
		status   = '0;
		sckLast  = sckO;
		sckEdges = 0;
		ioAddr   = addr;
		dbusIn   = data;
		ioWe     = 1'b1;
		@(posedge cp2);
		cycles   = 0;
		flagSeen = 1'b0;
		// Poll status until SPIF or a bound past the nominal length
		while (!flagSeen && cycles <= 8 * ratio + 16) begin
			#1;
			if (collide && cycles == 2) begin
				ioAddr = addr;	// Second write while busy
				dbusIn = ~data;
				ioWe   = 1'b1;
				ioRe   = 1'b0;
			end else begin
				ioAddr = spiPkg::defaultSpsrAddr;
				ioWe   = 1'b0;
				ioRe   = 1'b1;
			end
			@(negedge cp2);
			if (cycles == 0) begin
				// CPHA 1 leads with an edge right at the start
				checkBit("sckO_o first half", sckO,
					ctrlShadow[spiPkg::cpolBit] ^ ctrlShadow[spiPkg::cphaBit]);
			end
			if (sckO !== sckLast) begin
				sckEdges++;
			end
			sckLast = sckO;
			if (ioRe) begin
				status   = dbusOut;
				flagSeen = status[spiPkg::spifBit];
			end
			if (!flagSeen) begin
				@(posedge cp2);
				cycles++;
			end
		end
		@(posedge cp2);
		#1;
		ioRe   = 1'b0;
		ioAddr = '0;
		if (!flagSeen) begin
			errorCount++;
			$display("Master transfer of %02h never set SPIF at %0t", data, $time);
		end else begin
			compareLength("master transfer cycles", cycles, 8 * ratio);
			compareLength("sckO_o edges", sckEdges, 16);	// Two per bit
			checkBit("sckO_o", sckO, ctrlShadow[spiPkg::cpolBit]);	// Parked at CPOL
			if (collide) begin
				checkBit("WCOL", status[spiPkg::wcolBit], 1'b1);
			end
		end
		if (readBack) begin
			busRead(spiPkg::defaultSpdrAddr, rx, en);
			checkByte("rxData", rx, exp);
			checkBit("outEn_o", en, 1'b1);
		end
		loopBack = 1'b0;
	endtask

	// Drives one byte as an external master and checks MISO bit by bit
	task automatic slaveTransfer(input spiPkg::byteT data, input spiPkg::byteT exp);
		logic cpol;
		logic cpha;
		logic lsbFirst;
		int   idx;
		cpol     = ctrlShadow[spiPkg::cpolBit];
		cpha     = ctrlShadow[spiPkg::cphaBit];
		lsbFirst = ctrlShadow[spiPkg::dordBit];
		sck = cpol;
		waitCycles(halfBitCycles);
		ss = 1'b0;
		waitCycles(halfBitCycles);
		for (int i = 0; i < 8; i++) begin
			idx  = lsbFirst ? i : 7 - i;
			mosi = data[idx];
			if (cpha) begin
				sck = ~cpol;	// Leading edge changes data
			end
			waitCycles(halfBitCycles);
			checkBit("misoO_o", misoO, exp[idx]);
			sck = ~sck;	// Sampling edge
			waitCycles(halfBitCycles);
			if (!cpha) begin
				sck = cpol;
			end
		end
		waitCycles(halfBitCycles);
		ss = 1'b1;
		waitCycles(4);
	endtask

	task automatic readVectors();
		int              fd;
		int              code;
		spiPkg::byteT    op;
		spiPkg::byteT    a;
		spiPkg::byteT    d;
		spiPkg::byteT    e;
		logic [8*80-1:0] rest;
		vecCount = 0;
		fd = $fopen("verification/spiVectors.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("Cannot open the vector file");
		end else begin
			while (!$feof(fd) && vecCount < maxVectors) begin
				code = $fscanf(fd, " %c", op);
				if (code != 1) begin
					break;
				end
				if (op == "#") begin
					code = $fgets(rest, fd);	// Skip comment line
				end else begin
					code = $fscanf(fd, "%h %h %h", a, d, e);
					if (code != 3) begin
						errorCount++;
						$display("Malformed vector line after entry %0d", vecCount);
					end else begin
						opTab[vecCount]   = op;
						addrTab[vecCount] = a;
						dataTab[vecCount] = d;
						expTab[vecCount]  = e;
						vecCount++;
					end
					code = $fgets(rest, fd);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runVector(input int k);
		spiPkg::byteT   value;
		logic           en;
		spiPkg::ioAddrT addr;
		addr = addrTab[k][5:0];
		case (opTab[k])
			"W": busWrite(addr, dataTab[k]);
			"R": begin
				busRead(addr, value, en);
				checkByte($sformatf("register %02h", addr), value, expTab[k]);
				checkBit("outEn_o", en, 1'b1);
			end
			"M": masterTransfer(addr, dataTab[k], expTab[k], 1'b1, 1'b0);
			"C": masterTransfer(addr, dataTab[k], expTab[k], 1'b1, 1'b1);
			"T": masterTransfer(addr, dataTab[k], expTab[k], 1'b0, 1'b0);
			"S": slaveTransfer(dataTab[k], expTab[k]);
			"A": begin
				irqAckAddr = addr;
				irqAck     = 1'b1;
				waitCycles(1);
				irqAck     = 1'b0;
			end
			"I": checkBit("spiIrq_o", spiIrq, expTab[k][0]);
			"F": begin
				ss = 1'b0;	// Mode fault pulse
				waitCycles(1);
				ss = 1'b1;
				ctrlShadow[spiPkg::mstrBit] = 1'b0;
				waitCycles(1);
			end
			default: begin
				errorCount++;
				$display("Unknown operation in vector %0d", k);
			end
		endcase
	endtask

	//********************
	// Watchdog
	//********************
	initial begin
		wait (vecLoaded);
		#((vecCount + 1) * vectorBudget);
		$display("Timeout, the vectors did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		cp2         = 1'b0;
		irst        = 1'b0;
		ioAddr      = '0;
		ioRe        = 1'b0;
		ioWe        = 1'b0;
		dbusIn      = '0;
		mosi        = 1'b0;
		sck         = 1'b0;
		ss          = 1'b1;
		irqAckAddr  = '0;
		irqAck      = 1'b0;
		loopBack    = 1'b0;
		ctrlShadow  = '0;
		spi2xShadow = 1'b0;
		errorCount  = 0;
		checkCount  = 0;
		vecLoaded   = 1'b0;
		readVectors();
		vecLoaded = 1'b1;
		repeat (resetCycles) @(posedge cp2);
		#1;
		irst = 1'b1;
		waitCycles(2);
		checkBit("sckO_o", sckO, 1'b0);
		checkBit("spiIrq_o", spiIrq, 1'b0);
		for (int k = 0; k < vecCount; k++) begin
			runVector(k);
		end
		waitCycles(2);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* src/spiTop.sv */
module spiTop #(
	parameter spiPkg::ioAddrT spcrAddr = spiPkg::defaultSpcrAddr,
	parameter spiPkg::ioAddrT spsrAddr = spiPkg::defaultSpsrAddr,
	parameter spiPkg::ioAddrT spdrAddr = spiPkg::defaultSpdrAddr,
	parameter spiPkg::ioAddrT irqAddr  = spiPkg::defaultIrqAddr
) (
	input  logic           cp2,
	input  logic           irst,
	// I/O bus
	input  spiPkg::ioAddrT ioAddr_i,
	input  logic           ioRe_i,
	input  logic           ioWe_i,
	input  spiPkg::byteT   dbus_i,
	output spiPkg::byteT   dbus_o,
	output logic           outEn_o,
	// Serial lines
	input  logic           miso_i,
	input  logic           mosi_i,
	input  logic           sck_i,
	input  logic           ss_i,
	output logic           sckO_o,
	output logic           mosiO_o,
	output logic           misoO_o,
	// Interrupt
	output logic           spiIrq_o,
	input  spiPkg::ioAddrT irqAckAddr_i,
	input  logic           irqAck_i
);

	spiPkg::byteT ctrl;
	spiPkg::byteT rxData;
	logic         spi2x;
	logic         spcrWr;
	logic         spdrWr;
	logic         spdrAcc;
	logic         spsrRd;
	logic         trStart;
	logic         spif;
	logic         wcol;
	logic         masterBusy;
	logic         masterDone;
	logic         mstSample;
	logic         mstShift;
	logic         slaveBusy;
	logic         slaveDone;
	logic         slvSample;
	logic         slvShift;

	//********************
	// Bus side
	//********************
	spiControlRegs #(
		.spcrAddr(spcrAddr),
		.spsrAddr(spsrAddr),
		.spdrAddr(spdrAddr)
	) i_controlRegs (
		.cp2      (cp2),
		.irst     (irst),
		.ioAddr_i (ioAddr_i),
		.ioRe_i   (ioRe_i),
		.ioWe_i   (ioWe_i),
		.dbus_i   (dbus_i),
		.ss_i     (ss_i),
		.spif_i   (spif),
		.wcol_i   (wcol),
		.rxData_i (rxData),
		.ctrl_o   (ctrl),
		.spi2x_o  (spi2x),
		.spcrWr_o (spcrWr),
		.spdrWr_o (spdrWr),
		.spdrAcc_o(spdrAcc),
		.spsrRd_o (spsrRd),
		.trStart_o(trStart),
		.dbus_o   (dbus_o),
		.outEn_o  (outEn_o)
	);

	spiStatusFlags #(
		.irqAddr(irqAddr)
	) i_statusFlags (
		.cp2         (cp2),
		.irst        (irst),
		.spie_i      (ctrl[spiPkg::spieBit]),
		.spe_i       (ctrl[spiPkg::speBit]),
		.mstr_i      (ctrl[spiPkg::mstrBit]),
		.ss_i        (ss_i),
		.spsrRd_i    (spsrRd),
		.spdrWr_i    (spdrWr),
		.spdrAcc_i   (spdrAcc),
		.masterBusy_i(masterBusy),
		.masterDone_i(masterDone),
		.slaveBusy_i (slaveBusy),
		.slaveDone_i (slaveDone),
		.slvSample_i (slvSample),
		.irqAckAddr_i(irqAckAddr_i),
		.irqAck_i    (irqAck_i),
		.spif_o      (spif),
		.wcol_o      (wcol),
		.spiIrq_o    (spiIrq_o)
	);

	//********************
	// Serial side
	//********************
	spiMaster i_master (
		.cp2         (cp2),
		.irst        (irst),
		.ctrl_i      (ctrl),
		.spi2x_i     (spi2x),
		.spcrWr_i    (spcrWr),
		.cpolWr_i    (dbus_i[spiPkg::cpolBit]),
		.trStart_i   (trStart),
		.sckO_o      (sckO_o),
		.masterBusy_o(masterBusy),
		.masterDone_o(masterDone),
		.mstSample_o (mstSample),
		.mstShift_o  (mstShift)
	);

	spiSlave i_slave (
		.cp2        (cp2),
		.irst       (irst),
		.mstr_i     (ctrl[spiPkg::mstrBit]),
		.cpol_i     (ctrl[spiPkg::cpolBit]),
		.cpha_i     (ctrl[spiPkg::cphaBit]),
		.sck_i      (sck_i),
		.ss_i       (ss_i),
		.slaveBusy_o(slaveBusy),
		.slaveDone_o(slaveDone),
		.slvSample_o(slvSample),
		.slvShift_o (slvShift)
	);

	spiShifter i_shifter (
		.cp2         (cp2),
		.irst        (irst),
		.mstr_i      (ctrl[spiPkg::mstrBit]),
		.dord_i      (ctrl[spiPkg::dordBit]),
		.cpha_i      (ctrl[spiPkg::cphaBit]),
		.trStart_i   (trStart),
		.dbus_i      (dbus_i),
		.miso_i      (miso_i),
		.mosi_i      (mosi_i),
		.mstSample_i (mstSample),
		.mstShift_i  (mstShift),
		.masterBusy_i(masterBusy),
		.masterDone_i(masterDone),
		.slvSample_i (slvSample),
		.slvShift_i  (slvShift),
		.slaveBusy_i (slaveBusy),
		.slaveDone_i (slaveDone),
		.mosiO_o     (mosiO_o),
		.misoO_o     (misoO_o),
		.rxData_o    (rxData)
	);

endmodule

/* src/spiShifter.sv */
module spiShifter (
	input  logic         cp2,
	input  logic         irst,
	input  logic         mstr_i,
	input  logic         dord_i,
	input  logic         cpha_i,
	input  logic         trStart_i,
	input  spiPkg::byteT dbus_i,
	input  logic         miso_i,
	input  logic         mosi_i,
	input  logic         mstSample_i,
	input  logic         mstShift_i,
	input  logic         masterBusy_i,
	input  logic         masterDone_i,
	input  logic         slvSample_i,
	input  logic         slvShift_i,
	input  logic         slaveBusy_i,
	input  logic         slaveDone_i,
	output logic         mosiO_o,
	output logic         misoO_o,
	output spiPkg::byteT rxData_o
);

	spiPkg::byteT shiftReg;
	spiPkg::byteT rxResult;
	spiPkg::byteT rxData;
	logic         tmpIn;	// Bit taken on the last sampling edge
	logic         updRx;
	logic         loadEn;
	logic         shiftEn;
	logic         xferDone;

	function automatic spiPkg::byteT revByte(input spiPkg::byteT value);
		spiPkg::byteT result;
		for (int i = 0; i < 8; i++) begin
			result[i] = value[7 - i];
		end
		return result;
	endfunction

	assign xferDone = mstr_i ? masterDone_i : slaveDone_i;
	assign loadEn   = trStart_i & ~masterBusy_i & ~slaveBusy_i & ~(~mstr_i & slvSample_i);
	assign shiftEn  = mstr_i ? (masterBusy_i & mstShift_i) : (slaveBusy_i & slvShift_i);

	// Slave CPHA 1 ends on a sample with the last bit still in tmpIn
	assign rxResult = (~mstr_i & cpha_i) ? {shiftReg[6:0], tmpIn} : shiftReg;

	always_ff @(posedge cp2) begin
		if (!irst) begin
			shiftReg <= '1;
			updRx    <= 1'b0;
		end else begin
			updRx <= xferDone;
			if (loadEn) begin
				shiftReg <= dord_i ? revByte(dbus_i) : dbus_i;
			end else if (mstr_i & updRx) begin
				shiftReg[7] <= 1'b1;	// MOSI idles high
			end else if (shiftEn) begin
				shiftReg <= {shiftReg[6:0], tmpIn};
			end
		end
	end

	// Input bit latch and receive buffer
	always_ff @(posedge cp2) begin
		if (mstr_i & mstSample_i) begin
			tmpIn <= miso_i;
		end else if (~mstr_i & slvSample_i) begin
			tmpIn <= mosi_i;
		end
		if (updRx) begin
			rxData <= dord_i ? revByte(rxResult) : rxResult;
		end
	end

	assign mosiO_o  = shiftReg[7];
	assign misoO_o  = shiftReg[7];
	assign rxData_o = rxData;

endmodule

/* src/spiSlave.sv */
module spiSlave (
	input  logic cp2,
	input  logic irst,
	input  logic mstr_i,
	input  logic cpol_i,
	input  logic cpha_i,
	input  logic sck_i,
	input  logic ss_i,
	output logic slaveBusy_o,
	output logic slaveDone_o,
	output logic slvSample_o,
	output logic slvShift_o
);

	typedef enum logic [3:0] {
		slvIdle,
		slvB0i,	// CPHA 0 lead-in after the first sample
		slvB0,
		slvB1,
		slvB2,
		slvB3,
		slvB4,
		slvB5,
		slvB6,
		slvB6w	// CPHA 1 wait for the last sample
	} slvStateT;

	slvStateT state;
	slvStateT stateNext;
	logic     sckPrev;
	logic     sckRise;
	logic     sckFall;
	logic     sampleEdge;
	logic     shiftEdge;

	assign sckRise = ~sckPrev & sck_i;
	assign sckFall = sckPrev & ~sck_i;

	// Modes 0 and 3 sample on the rising edge
	assign sampleEdge  = (cpol_i == cpha_i) ? sckRise : sckFall;
	assign shiftEdge   = (cpol_i == cpha_i) ? sckFall : sckRise;
	assign slvSample_o = sampleEdge & ~ss_i;
	assign slvShift_o  = shiftEdge & ~ss_i;

	always_comb begin
		stateNext = state;
		if (!ss_i) begin
			case (state)
				slvIdle: begin
					if (!mstr_i) begin
						if (cpha_i && slvShift_o) begin
							stateNext = slvB0;
						end else if (!cpha_i && slvSample_o) begin
							stateNext = slvB0i;
						end
					end
				end
				slvB6: begin
					if (slvShift_o) begin
						stateNext = cpha_i ? slvB6w : slvIdle;
					end
				end
				slvB6w: begin
					if (slvSample_o) begin
						stateNext = slvIdle;
					end
				end
				default: begin
					if (slvShift_o) begin
						stateNext = slvStateT'(state + 4'd1);
					end
				end
			endcase
		end
	end

	assign slaveBusy_o = (state != slvIdle);
	assign slaveDone_o = slaveBusy_o & (stateNext == slvIdle);

	always_ff @(posedge cp2) begin
		if (!irst) begin
			state   <= slvIdle;
			sckPrev <= 1'b0;
		end else begin
			state   <= stateNext;
			sckPrev <= sck_i;
		end
	end

endmodule

/* src/spiMaster.sv */
module spiMaster (
	input  logic         cp2,
	input  logic         irst,
	input  spiPkg::byteT ctrl_i,
	input  logic         spi2x_i,
	input  logic         spcrWr_i,
	input  logic         cpolWr_i,
	input  logic         trStart_i,
	output logic         sckO_o,
	output logic         masterBusy_o,
	output logic         masterDone_o,
	output logic         mstSample_o,
	output logic         mstShift_o
);

	typedef enum logic [3:0] {
		mstIdle,
		mstB0,
		mstB1,
		mstB2,
		mstB3,
		mstB4,
		mstB5,
		mstB6,
		mstB7
	} mstStateT;

	mstStateT   state;
	mstStateT   stateNext;
	logic [5:0] divCnt;
	logic [5:0] divLimit;
	logic       divToggle;
	logic       halfSel;	// Second half of the bit period
	logic       sckReg;
	logic       sckNext;
	logic       startXfer;
	logic       cpol;
	logic       cpha;

	assign cpol         = ctrl_i[spiPkg::cpolBit];
	assign cpha         = ctrl_i[spiPkg::cphaBit];
	assign startXfer    = trStart_i & ctrl_i[spiPkg::mstrBit] & (state == mstIdle);
	assign masterBusy_o = (state != mstIdle);

	// Terminal count of the half-period counter
	always_comb begin
		case ({spi2x_i, ctrl_i[spiPkg::spr1Bit], ctrl_i[spiPkg::spr0Bit]})
			3'b000:  divLimit = 6'd1;	// fosc/4
			3'b001:  divLimit = 6'd7;	// fosc/16
			3'b010:  divLimit = 6'd31;	// fosc/64
			3'b011:  divLimit = 6'd63;	// fosc/128
			3'b100:  divLimit = 6'd0;	// fosc/2
			3'b101:  divLimit = 6'd3;	// fosc/8
			3'b110:  divLimit = 6'd15;	// fosc/32
			default: divLimit = 6'd31;	// fosc/64
		endcase
	end

	assign divToggle    = masterBusy_o & (divCnt == divLimit);
	assign mstShift_o   = divToggle & halfSel;
	assign masterDone_o = mstShift_o & (state == mstB7);

	// Bit FSM advances at the end of each full bit period
	always_comb begin
		stateNext = state;
		if (startXfer) begin
			stateNext = mstB0;
		end else if (mstShift_o) begin
			if (state == mstB7) begin
				stateNext = mstIdle;
			end else begin
				stateNext = mstStateT'(state + 4'd1);
			end
		end
	end

	//********************
	// Serial clock
	//********************
	always_comb begin
		sckNext = sckReg;
		if (spcrWr_i) begin
			sckNext = cpolWr_i;	// Idle level follows CPOL
		end else if (startXfer & cpha) begin
			sckNext = ~cpol;	// Leading edge at start
		end else if (masterDone_o) begin
			sckNext = cpol;	// Park
		end else if (divToggle) begin
			sckNext = ~sckReg;
		end
	end

	// Rising edge samples when CPOL equals CPHA, falling edge otherwise
	assign mstSample_o = divToggle & (sckNext != sckReg) & (sckNext == (cpol ~^ cpha));

	always_ff @(posedge cp2) begin
		if (!irst) begin
			state   <= mstIdle;
			divCnt  <= '0;
			halfSel <= 1'b0;
			sckReg  <= 1'b0;
		end else begin
			state  <= stateNext;
			sckReg <= sckNext;
			if (startXfer) begin
				divCnt  <= '0;
				halfSel <= 1'b0;
			end else if (divToggle) begin
				divCnt  <= '0;
				halfSel <= ~halfSel;
			end else if (masterBusy_o) begin
				divCnt <= divCnt + 6'd1;
			end
		end
	end

	assign sckO_o = sckReg;

endmodule

/* src/spiStatusFlags.sv */
module spiStatusFlags #(
	parameter spiPkg::ioAddrT irqAddr = spiPkg::defaultIrqAddr
) (
	input  logic           cp2,
	input  logic           irst,
	input  logic           spie_i,
	input  logic           spe_i,
	input  logic           mstr_i,
	input  logic           ss_i,
	input  logic           spsrRd_i,
	input  logic           spdrWr_i,
	input  logic           spdrAcc_i,
	input  logic           masterBusy_i,
	input  logic           masterDone_i,
	input  logic           slaveBusy_i,
	input  logic           slaveDone_i,
	input  logic           slvSample_i,
	input  spiPkg::ioAddrT irqAckAddr_i,
	input  logic           irqAck_i,
	output logic           spif_o,
	output logic           wcol_o,
	output logic           spiIrq_o
);

	logic spifReg;
	logic wcolReg;
	logic spifClrArmed;	// Status read seen and waiting for data access
	logic wcolClrArmed;
	logic xferEnd;
	logic modeFault;
	logic busy;
	logic wcolSet;
	logic irqAckHit;

	assign xferEnd   = mstr_i ? masterDone_i : slaveDone_i;
	assign modeFault = mstr_i & ~ss_i;
	// A slave counts as busy from its first sampling edge
	assign busy      = mstr_i ? masterBusy_i : (slaveBusy_i | slvSample_i);
	assign wcolSet   = spdrWr_i & busy;
	assign irqAckHit = irqAck_i & (irqAckAddr_i == irqAddr);

	always_ff @(posedge cp2) begin
		if (!irst) begin
			spifReg      <= 1'b0;
			wcolReg      <= 1'b0;
			spifClrArmed <= 1'b0;
			wcolClrArmed <= 1'b0;
		end else begin
			//********************
			// SPIF and its clear sequence
			//********************
			if (!spifReg) begin
				if (xferEnd | modeFault) begin
					spifReg <= 1'b1;
				end
			end else if ((spdrAcc_i & spifClrArmed) | irqAckHit) begin
				spifReg <= 1'b0;
			end
			if (!spifClrArmed) begin
				if (spsrRd_i & spifReg & spe_i) begin
					spifClrArmed <= 1'b1;
				end
			end else if (spdrAcc_i) begin
				spifClrArmed <= 1'b0;
			end
			//********************
			// WCOL and its clear sequence
			//********************
			if (!wcolReg) begin
				if (wcolSet) begin
					wcolReg <= 1'b1;
				end
			end else if (spdrAcc_i & wcolClrArmed & ~wcolSet) begin
				wcolReg <= 1'b0;	// A new collision keeps it set
			end
			if (!wcolClrArmed) begin
				if (spsrRd_i & wcolReg) begin
					wcolClrArmed <= 1'b1;
				end
			end else if (spdrAcc_i) begin
				wcolClrArmed <= 1'b0;
			end
		end
	end

	assign spif_o   = spifReg;
	assign wcol_o   = wcolReg;
	assign spiIrq_o = spie_i & spifReg;

endmodule

/* src/spiControlRegs.sv */
module spiControlRegs #(
	parameter spiPkg::ioAddrT spcrAddr = spiPkg::defaultSpcrAddr,
	parameter spiPkg::ioAddrT spsrAddr = spiPkg::defaultSpsrAddr,
	parameter spiPkg::ioAddrT spdrAddr = spiPkg::defaultSpdrAddr
) (
	input  logic           cp2,
	input  logic           irst,
	input  spiPkg::ioAddrT ioAddr_i,
	input  logic           ioRe_i,
	input  logic           ioWe_i,
	input  spiPkg::byteT   dbus_i,
	input  logic           ss_i,
	input  logic           spif_i,
	input  logic           wcol_i,
	input  spiPkg::byteT   rxData_i,
	output spiPkg::byteT   ctrl_o,
	output logic           spi2x_o,
	output logic           spcrWr_o,
	output logic           spdrWr_o,
	output logic           spdrAcc_o,
	output logic           spsrRd_o,
	output logic           trStart_o,
	output spiPkg::byteT   dbus_o,
	output logic           outEn_o
);

	logic         spcrSel;
	logic         spsrSel;
	logic         spdrSel;
	logic         spsrWr;
	logic         spi2xReg;
	spiPkg::byteT ctrlReg;
	spiPkg::byteT statusByte;

	// Address decode
	assign spcrSel = (ioAddr_i == spcrAddr);
	assign spsrSel = (ioAddr_i == spsrAddr);
	assign spdrSel = (ioAddr_i == spdrAddr);

	assign spcrWr_o  = spcrSel & ioWe_i;
	assign spsrWr    = spsrSel & ioWe_i;	// Only SPI2X is writable
	assign spsrRd_o  = spsrSel & ioRe_i;
	assign spdrWr_o  = spdrSel & ioWe_i;
	assign spdrAcc_o = spdrSel & (ioRe_i | ioWe_i);
	assign trStart_o = spdrWr_o & ctrlReg[spiPkg::speBit];

	always_ff @(posedge cp2) begin
		if (!irst) begin
			ctrlReg  <= '0;
			spi2xReg <= 1'b0;
		end else begin
			if (spcrWr_o) begin
				ctrlReg <= dbus_i;
			end
			// Mode fault drops a master back to slave
			if (ctrlReg[spiPkg::mstrBit] && !ss_i) begin
				ctrlReg[spiPkg::mstrBit] <= 1'b0;
			end
			if (spsrWr) begin
				spi2xReg <= dbus_i[spiPkg::spi2xBit];
			end
		end
	end

	always_comb begin
		statusByte = '0;	// Unused bits read as zero
		statusByte[spiPkg::spifBit]  = spif_i;
		statusByte[spiPkg::wcolBit]  = wcol_i;
		statusByte[spiPkg::spi2xBit] = spi2xReg;
	end

	// Read multiplexer
	always_comb begin
		dbus_o  = '0;
		outEn_o = 1'b0;
		if (spcrSel) begin
			dbus_o  = ctrlReg;
			outEn_o = ioRe_i;
		end else if (spsrSel) begin
			dbus_o  = statusByte;
			outEn_o = ioRe_i;
		end else if (spdrSel) begin
			dbus_o  = rxData_i;
			outEn_o = ioRe_i;
		end
	end

	assign ctrl_o  = ctrlReg;
	assign spi2x_o = spi2xReg;

endmodule

/* src/spiPkg.sv */
package spiPkg;

	typedef logic [5:0] ioAddrT;	// I/O space word address
	typedef logic [7:0] byteT;

	//********************
	// Control register bit positions
	//********************
	typedef enum int unsigned {
		spr0Bit = 0,	// Clock rate select, low bit
		spr1Bit = 1,
		cphaBit = 2,
		cpolBit = 3,
		mstrBit = 4,
		dordBit = 5,	// Set for LSB first
		speBit  = 6,
		spieBit = 7
	} ctrlBitE;

	//********************
	// Status register bit positions
	//********************
	typedef enum int unsigned {
		spi2xBit = 0,
		wcolBit  = 6,
		spifBit  = 7
	} statusBitE;

	// Default I/O map
	localparam ioAddrT defaultSpcrAddr = 6'h2C;
	localparam ioAddrT defaultSpsrAddr = 6'h2D;
	localparam ioAddrT defaultSpdrAddr = 6'h2E;
	localparam ioAddrT defaultIrqAddr  = 6'h11;	// Interrupt vector slot

endpackage
